// ==== filelist.f ====
uart_pkg.sv
uart_rx.sv
uart_tx.sv
uart_regs.sv
uart_apb_top.sv
tb_uart_apb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_uart_apb
FILELIST  := filelist.f
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build folder"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_uart_apb.sv ====
`timescale 1ns/1ns

module tb_uart_apb;
    import uart_pkg::*;

    localparam int N_TX       = 10;
    localparam int N_RX       = 10;
    localparam int NUM_FRAMES = N_TX + 2 + N_RX + 5;   // busy test 2, overwrite/framing 5
    localparam int TIMEOUT_NS = (NUM_FRAMES + 20) * 12 * CLKS_PER_BIT * 8;
    localparam logic [APB_ADDR_W-1:0] ADDR_NONE = 12'h100;

    logic                  clk;
    logic                  locked;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic                  rxd;
    reg_word_u             prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  txd;

    logic [31:0]          rng_state = 32'd47078;
    logic [DATA_BITS-1:0] exp_q[$];   // bytes written to the transmitter
    logic [DATA_BITS-1:0] mon_q[$];   // bytes decoded from txd
    logic [DATA_BITS-1:0] model_buf = '0;
    logic                 model_avail = 1'b0;

    uart_apb_top uut (
        .clk_i     (clk),
        .locked_i  (locked),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .rxd_i     (rxd),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .txd_o     (txd)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic reg_word_u stat_word(input logic ready, input logic avail);
        reg_word_u w;
        w = '0;
        w.stat.tx_ready = ready;
        w.stat.rx_avail = avail;
        return w;
    endfunction

    function automatic reg_word_u data_word(input logic [DATA_BITS-1:0] b);
        reg_word_u w;
        w = '0;
        w.data.rx_byte = b;
        return w;
    endfunction

    task automatic stop_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input reg_word_u got, input reg_word_u exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_byte(input logic [DATA_BITS-1:0] got, input logic [DATA_BITS-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // every stimulus step lands 1 ns after a rising edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output reg_word_u data,
                            output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        step_cycle();
        penable = 1'b1;
        #2;   // access cycle, outputs settled
        data = prdata;
        err  = pslverr;
        check_bit(pready, 1'b1, "pready in access cycle");
        step_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [APB_DATA_W-1:0] data,
                             output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        step_cycle();
        penable = 1'b1;
        #2;
        err = pslverr;
        check_bit(pready, 1'b1, "pready in access cycle");
        step_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic wait_tx_ready();
        reg_word_u w;
        logic      err;
        do begin
            apb_read(ADDR_STAT, w, err);
        end while (!w.stat.tx_ready);
    endtask

    task automatic wait_rx_avail();
        reg_word_u w;
        logic      err;
        do begin
            apb_read(ADDR_STAT, w, err);
        end while (!w.stat.rx_avail);
    endtask

    // start, 8 data lsb first, stop
    task automatic send_serial(input logic [DATA_BITS-1:0] b, input logic bad_stop);
        rxd = 1'b0;
        repeat (CLKS_PER_BIT) step_cycle();
        for (int i = 0; i < DATA_BITS; i++) begin
            rxd = b[i];
            repeat (CLKS_PER_BIT) step_cycle();
        end
        rxd = ~bad_stop;
        repeat (CLKS_PER_BIT) step_cycle();
        rxd = 1'b1;
    endtask

    task automatic model_rx(input logic [DATA_BITS-1:0] b, input logic bad_stop);
        if (!bad_stop) begin
            model_buf   = b;   // overwrite keeps avail set
            model_avail = 1'b1;
        end
    endtask

    task automatic read_and_check_rx();
        reg_word_u w;
        logic      err;
        apb_read(ADDR_DATA, w, err);
        check_word(w, data_word(model_buf), "rx data read");
        check_bit(err, 1'b0, "pslverr on data read");
        model_avail = 1'b0;
        apb_read(ADDR_STAT, w, err);
        check_word(w, stat_word(1'b1, model_avail), "status after data read");
    endtask

    task automatic compare_tx_bytes();
        while (mon_q.size() < exp_q.size()) step_cycle();
        while (exp_q.size() != 0) begin
            check_byte(mon_q.pop_front(), exp_q.pop_front(), "byte decoded from txd");
        end
    endtask

    initial begin : tx_monitor
        logic [DATA_BITS-1:0] b;
        wait (locked === 1'b1);
        forever begin
            @(negedge txd);
            repeat (HALF_BIT) @(posedge clk);
            #1;
            check_bit(txd, 1'b0, "tx start bit");
            for (int i = 0; i < DATA_BITS; i++) begin
                repeat (CLKS_PER_BIT) @(posedge clk);
                #1;
                b[i] = txd;
            end
            repeat (CLKS_PER_BIT) @(posedge clk);
            #1;
            check_bit(txd, 1'b1, "tx stop bit");
            mon_q.push_back(b);
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("error: timeout, the tests did not finish within %0d ns", TIMEOUT_NS);
        stop_with_failure();
    end

    initial begin : main
        reg_word_u            rd;
        logic                 err;
        logic [31:0]          w32;
        logic [DATA_BITS-1:0] b;
        int                   gap;

        locked  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        rxd     = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        locked = 1'b1;

        // reset values and address decode
        check_bit(txd, 1'b1, "txd idle after reset");
        apb_read(ADDR_STAT, rd, err);
        check_word(rd, stat_word(1'b1, 1'b0), "status after reset");
        check_bit(err, 1'b0, "pslverr on status read");
        apb_read(ADDR_NONE, rd, err);
        check_bit(err, 1'b1, "pslverr on unmapped read");
        check_word(rd, '0, "unmapped read data");
        apb_write(ADDR_STAT, 32'hFFFF_FFFF, err);   // accepted, no effect
        check_bit(err, 1'b0, "pslverr on status write");

        // transmit random bytes
        for (int n = 0; n < N_TX; n++) begin
            gap = next_rand() % 8;
            repeat (gap) step_cycle();
            wait_tx_ready();
            w32 = next_rand();
            apb_write(ADDR_DATA, w32, err);
            check_bit(err, 1'b0, "pslverr on data write");
            exp_q.push_back(w32[7:0]);
        end
        compare_tx_bytes();

        // second write while busy is lost
        wait_tx_ready();
        w32 = next_rand();
        apb_write(ADDR_DATA, w32, err);
        exp_q.push_back(w32[7:0]);
        apb_read(ADDR_STAT, rd, err);
        check_word(rd, stat_word(1'b0, model_avail), "status right after data write");
        apb_write(ADDR_DATA, next_rand(), err);
        check_bit(err, 1'b0, "pslverr on write while busy");
        compare_tx_bytes();
        repeat (12 * CLKS_PER_BIT) step_cycle();
        if (mon_q.size() != 0) begin
            $display("error: transmitter sent a byte that was written while it was busy");
            stop_with_failure();
        end

        // receive random frames
        for (int n = 0; n < N_RX; n++) begin
            gap = next_rand() % 16;
            repeat (gap) step_cycle();
            w32 = next_rand();
            b = w32[23:16];
            send_serial(b, 1'b0);
            model_rx(b, 1'b0);
            wait_rx_avail();
            read_and_check_rx();
        end

        // two frames without a read, the second one stays
        for (int n = 0; n < 2; n++) begin
            w32 = next_rand();
            b = w32[23:16];
            send_serial(b, 1'b0);
            model_rx(b, 1'b0);
        end
        wait_rx_avail();
        read_and_check_rx();

        // bad stop bit after a good frame
        w32 = next_rand();
        send_serial(w32[23:16], 1'b0);
        model_rx(w32[23:16], 1'b0);
        send_serial(w32[15:8], 1'b1);
        model_rx(w32[15:8], 1'b1);
        apb_read(ADDR_STAT, rd, err);
        check_word(rd, stat_word(1'b1, model_avail), "status after framing error");
        read_and_check_rx();

        // bad stop bit with an empty buffer
        repeat (4) step_cycle();
        w32 = next_rand();
        send_serial(w32[23:16], 1'b1);
        model_rx(w32[23:16], 1'b1);
        repeat (CLKS_PER_BIT) step_cycle();
        apb_read(ADDR_STAT, rd, err);
        check_word(rd, stat_word(1'b1, model_avail), "status after bad frame, empty buffer");
        apb_read(ADDR_DATA, rd, err);
        check_word(rd, data_word(model_buf), "buffer kept after bad frame");

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== uart_apb_top.sv ====
`timescale 1ns/1ns

module uart_apb_top (
    input  logic                            clk_i,
    input  logic                            locked_i,
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  logic [uart_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic [uart_pkg::APB_DATA_W-1:0] pwdata_i,
    input  logic                            rxd_i,
    output uart_pkg::reg_word_u             prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,
    output logic                            txd_o
);
    import uart_pkg::*;

    // receiver to register block
    logic                 rx_valid;
    logic [DATA_BITS-1:0] rx_byte;

    // register block and transmitter
    logic                 tx_start;
    logic [DATA_BITS-1:0] tx_byte;
    logic                 tx_busy;

    uart_rx u_rx (
        .clk_i      (clk_i),
        .locked_i   (locked_i),
        .rxd_i      (rxd_i),
        .rx_valid_o (rx_valid),
        .rx_byte_o  (rx_byte)
    );

    uart_tx u_tx (
        .clk_i      (clk_i),
        .locked_i   (locked_i),
        .tx_start_i (tx_start),
        .tx_byte_i  (tx_byte),
        .tx_busy_o  (tx_busy),
        .txd_o      (txd_o)
    );

    uart_regs u_regs (
        .clk_i      (clk_i),
        .locked_i   (locked_i),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .rx_valid_i (rx_valid),
        .rx_byte_i  (rx_byte),
        .tx_busy_i  (tx_busy),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .tx_start_o (tx_start),
        .tx_byte_o  (tx_byte)
    );

endmodule

// ==== uart_regs.sv ====
`timescale 1ns/1ns

module uart_regs (
    input  logic                            clk_i,
    input  logic                            locked_i,
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  logic [uart_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic [uart_pkg::APB_DATA_W-1:0] pwdata_i,
    input  logic                            rx_valid_i,
    input  logic [uart_pkg::DATA_BITS-1:0]  rx_byte_i,
    input  logic                            tx_busy_i,
    output uart_pkg::reg_word_u             prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,
    output logic                            tx_start_o,
    output logic [uart_pkg::DATA_BITS-1:0]  tx_byte_o
);
    import uart_pkg::*;

    logic                 access;
    logic                 hit_data;
    logic                 hit_stat;
    logic                 rd_data;
    logic                 rx_avail_q;
    logic [DATA_BITS-1:0] rx_buf_q;

    assign access   = psel_i & penable_i;   // apb access phase
    assign hit_data = (paddr_i == ADDR_DATA);
    assign hit_stat = (paddr_i == ADDR_STAT);
    assign rd_data  = access & ~pwrite_i & hit_data;

    assign pready_o  = 1'b1;   // no wait states
    assign pslverr_o = access & ~(hit_data | hit_stat);

    // a data write while busy is simply lost
    assign tx_start_o = access & pwrite_i & hit_data & ~tx_busy_i;
    assign tx_byte_o  = pwdata_i[DATA_BITS-1:0];

    // new byte wins over a read in the same cycle
    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            rx_avail_q <= 1'b0;
        end else if (rx_valid_i) begin
            rx_avail_q <= 1'b1;
        end else if (rd_data) begin
            rx_avail_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rx_valid_i) begin
            rx_buf_q <= rx_byte_i;   // overwrite, no back-pressure
        end
    end

    always_comb begin
        prdata_o = '0;
        if (hit_data) begin
            prdata_o.data.rx_byte = rx_buf_q;
        end else if (hit_stat) begin
            prdata_o.stat.tx_ready = ~tx_busy_i;
            prdata_o.stat.rx_avail = rx_avail_q;
        end
    end

    // master never raises penable outside a selected transfer
    a_enable_sel: assert property (
        @(posedge clk_i) disable iff (!locked_i) penable_i |-> psel_i);

    // transmitter takes the byte and reports busy one edge later
    a_start_busy: assert property (
        @(posedge clk_i) disable iff (!locked_i) tx_start_o |=> tx_busy_i);

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx (
    input  logic                           clk_i,
    input  logic                           locked_i,
    input  logic                           tx_start_i,
    input  logic [uart_pkg::DATA_BITS-1:0] tx_byte_i,
    output logic                           tx_busy_o,
    output logic                           txd_o
);
    import uart_pkg::*;

    logic [DATA_BITS:0]     shift_q;   // stop bit on top of the data
    logic [BIT_CNT_W-1:0]   cnt_q;
    logic [FRAME_CNT_W-1:0] bit_q;     // bit now on the line
    logic                   bit_end;
    logic                   last_bit;

    assign bit_end  = (cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1));
    assign last_bit = (bit_q == FRAME_CNT_W'(FRAME_BITS - 1));

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            tx_busy_o <= 1'b0;
            txd_o     <= 1'b1;   // line idles high
            cnt_q     <= '0;
            bit_q     <= '0;
        end else if (tx_busy_o) begin
            if (bit_end) begin
                cnt_q <= '0;
                if (last_bit) begin
                    tx_busy_o <= 1'b0;   // end of stop bit
                    txd_o     <= 1'b1;
                end else begin
                    txd_o <= shift_q[0];
                    bit_q <= bit_q + 1'b1;
                end
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end else if (tx_start_i) begin
            tx_busy_o <= 1'b1;
            txd_o     <= 1'b0;   // start bit goes out right away
            cnt_q     <= '0;
            bit_q     <= '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!tx_busy_o && tx_start_i) begin
            shift_q <= {1'b1, tx_byte_i};
        end else if (tx_busy_o && bit_end && !last_bit) begin
            shift_q <= {1'b1, shift_q[DATA_BITS:1]};
        end
    end

    // register block must hold off while a frame is out
    a_no_start_busy: assert property (
        @(posedge clk_i) disable iff (!locked_i) tx_start_i |-> !tx_busy_o);

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx (
    input  logic                           clk_i,
    input  logic                           locked_i,
    input  logic                           rxd_i,
    output logic                           rx_valid_o,
    output logic [uart_pkg::DATA_BITS-1:0] rx_byte_o
);
    import uart_pkg::*;

    logic [1:0]           sync_q;    // two-flop synchronizer, idle high
    logic                 rxd_s;
    logic [1:0]           state_q;
    logic [BIT_CNT_W-1:0] cnt_q;
    logic [BIT_IDX_W-1:0] idx_q;
    logic [DATA_BITS-1:0] shift_q;
    logic                 half_end;
    logic                 bit_end;

    assign rxd_s     = sync_q[1];
    assign half_end  = (cnt_q == BIT_CNT_W'(HALF_BIT - 1));
    assign bit_end   = (cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1));
    assign rx_byte_o = shift_q;

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], rxd_i};
        end
    end

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            state_q    <= RX_IDLE;
            cnt_q      <= '0;
            idx_q      <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    if (!rxd_s) state_q <= RX_START;   // falling edge seen
                end
                RX_START: begin
                    if (half_end) begin
                        cnt_q <= '0;
                        idx_q <= '0;
                        // still low at mid bit, otherwise a glitch
                        state_q <= rxd_s ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        cnt_q <= '0;
                        if (idx_q == BIT_IDX_W'(DATA_BITS - 1)) begin
                            state_q <= RX_STOP;
                        end else begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin   // RX_STOP
                    if (bit_end) begin
                        cnt_q      <= '0;
                        state_q    <= RX_IDLE;
                        rx_valid_o <= rxd_s;   // framing error drops the byte
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb arrives first, shift in from the top
    always_ff @(posedge clk_i) begin
        if (state_q == RX_DATA && bit_end) begin
            shift_q <= {rxd_s, shift_q[DATA_BITS-1:1]};
        end
    end

    // a frame is at least ten bit times long
    a_rx_valid_pulse: assert property (
        @(posedge clk_i) disable iff (!locked_i) rx_valid_o |=> !rx_valid_o);

endmodule

// ==== uart_pkg.sv ====
package uart_pkg;

    // serial bit timing, kept short for simulation
    localparam int CLKS_PER_BIT = 16;
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;   // sample point inside a bit
    localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

    // frame format: start, 8 data, stop, no parity
    localparam int DATA_BITS   = 8;
    localparam int BIT_IDX_W   = $clog2(DATA_BITS);
    localparam int FRAME_BITS  = DATA_BITS + 2;
    localparam int FRAME_CNT_W = $clog2(FRAME_BITS);

    // apb side
    localparam int APB_ADDR_W = 12;
    localparam int APB_DATA_W = 32;

    localparam logic [APB_ADDR_W-1:0] ADDR_DATA = 12'h3F8;   // rx buffer / tx byte
    localparam logic [APB_ADDR_W-1:0] ADDR_STAT = 12'h3FC;

    // status word bit positions
    localparam int STAT_TX_READY_BIT = 0;
    localparam int STAT_RX_AVAIL_BIT = 1;

    // receiver fsm encoding
    localparam logic [1:0] RX_IDLE  = 2'd0;
    localparam logic [1:0] RX_START = 2'd1;
    localparam logic [1:0] RX_DATA  = 2'd2;
    localparam logic [1:0] RX_STOP  = 2'd3;

    // one read word, seen either as the data register or as the status register
    typedef union packed {
        struct packed {
            logic [APB_DATA_W-DATA_BITS-1:0] rsvd;
            logic [DATA_BITS-1:0]            rx_byte;
        } data;
        struct packed {
            logic [APB_DATA_W-3:0] rsvd;
            logic                  rx_avail;   // bit 1
            logic                  tx_ready;   // bit 0
        } stat;
    } reg_word_u;

endpackage
